/* Bender.yml */
package:
  name: tsqr_tile_ctrl

sources:
  - files:
      - src/tsqr_pkg.sv
      - src/noc_rx_decoder.sv
      - src/matrix_loader.sv
      - src/tile_buffer.sv
      - src/noc_tx_sequencer.sv
      - src/tsqr_tile_ctrl.sv
  - target: test
    files:
      - verification/tsqr_tile_tb.sv

/* src.f */
src/tsqr_pkg.sv
src/noc_rx_decoder.sv
src/matrix_loader.sv
src/tile_buffer.sv
src/noc_tx_sequencer.sv
src/tsqr_tile_ctrl.sv
verification/tsqr_tile_tb.sv

/* src/matrix_loader.sv */
/*
   matrix loader
   places each payload word in its lane and line of the selected input bank
*/
module matrix_loader import tsqr_pkg::*; (
   input  logic     clk_ctrl,
   input  logic     clk_ctrl_rst_low,
   input  stream_s  load_word,
   input  bank_e    load_bank,
   output line_wr_s line_wr
);

   logic [WORD_CNT_W-1:0] word_cnt;  // position inside the matrix
   line_addr_t            line_idx;
   lane_idx_t             lane_idx;
   int                    lane_shift;

   // registered write toward the buffer
   logic                  wr_en;
   bank_e                 wr_bank;
   line_addr_t            wr_addr;
   logic [LANES-1:0]      wr_mask;
   line_t                 wr_data;

   assign {line_idx, lane_idx} = word_cnt;

   // lane 0 sits in the top word of the line
   assign lane_shift = LANES - 1 - int'(lane_idx);

   ////////////////////////////////////////
   // word counter and write strobe
   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         word_cnt <= '0;
         wr_en    <= 1'b0;
      end else begin
         wr_en <= load_word.valid;
         if (load_word.valid) begin
            if (load_word.last) word_cnt <= '0;  // next matrix starts at line 0
            else word_cnt <= word_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // address, mask and shifted data
   always_ff @(posedge clk_ctrl) begin
      if (load_word.valid) begin
         wr_bank <= load_bank;
         wr_addr <= line_idx;
         wr_mask <= LANES'(1) << lane_shift;
         wr_data <= line_t'(load_word.data) << (lane_shift * WORD_W);
      end
   end

   assign line_wr = '{en:        wr_en,
                      bank:      wr_bank,
                      addr:      wr_addr,
                      lane_mask: wr_mask,
                      data:      wr_data};

endmodule

/* src/noc_rx_decoder.sv */
/*
   network receive decoder
   sorts short and long packets, keeps enable, request and bank state,
   and decides which packet the sequencer sends next
*/
module noc_rx_decoder import tsqr_pkg::*; (
   input  logic     clk_ctrl,
   input  logic     clk_ctrl_rst_low,
   input  stream_s  stream_in,
   input  logic     tx_busy,
   input  logic     tx_done,
   input  logic     kernel_done,
   output logic     stream_in_ready,
   output stream_s  load_word,
   output bank_e    load_bank,
   output logic     tx_start,
   output tx_kind_e tx_kind,
   output logic     kernel_start
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_SKIP_ADDR,
      RX_PAYLOAD,
      RX_SHORT_CMD
   } rx_state_e;

   rx_state_e   rx_state;
   logic        enabled;
   logic        pkt_requested;  // request sent, matrix not yet in
   logic        res_pending;    // kernel finished, result not yet sent
   logic        discard;        // current long packet is dropped
   logic [1:0]  bank_full;
   logic [1:0]  full_after;
   matrix_cnt_t matrix_cnt;
   tx_kind_e    last_kind;
   logic        in_fire;
   logic        is_short;
   logic        long_ok;
   logic        want_result;
   logic        want_request;

   assign stream_in_ready = ~tx_busy;
   assign in_fire         = stream_in.valid & stream_in_ready;

   assign is_short = ~stream_in.data[28] & (stream_in.data[23:18] == SHORT_TYPE_A ||
                                            stream_in.data[23:18] == SHORT_TYPE_B);
   assign long_ok  = enabled & pkt_requested & ~res_pending;

   // first free bank, stable for a whole packet
   assign load_bank  = bank_full[BANK_A] ? BANK_B : BANK_A;
   assign full_after = bank_full | (2'b01 << load_bank);

   assign want_result  = enabled & res_pending;
   assign want_request = enabled & ~res_pending & ~pkt_requested & ~(&bank_full) &
                         (matrix_cnt < MAX_MATRICES);

   assign load_word = '{valid: (rx_state == RX_PAYLOAD) & in_fire & ~discard,
                        data:  stream_in.data,
                        last:  stream_in.last};

   // incoming words win over a new outgoing packet
   always_comb begin
      tx_start = 1'b0;
      tx_kind  = TX_REQUEST;
      case (rx_state)
         RX_IDLE: begin
            if (!stream_in.valid && !tx_busy) begin
               if (want_result) begin
                  tx_start = 1'b1;
                  tx_kind  = TX_RESULT;
               end else if (want_request) begin
                  tx_start = 1'b1;
               end
            end
         end
         RX_SHORT_CMD: begin
            if (in_fire && stream_in.data == CMD_SPAD && pkt_requested) begin
               tx_start = 1'b1;
               tx_kind  = TX_SPAD;
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         rx_state      <= RX_IDLE;
         enabled       <= 1'b0;
         pkt_requested <= 1'b0;
         res_pending   <= 1'b0;
         discard       <= 1'b0;
         bank_full     <= 2'b00;
         matrix_cnt    <= '0;
         last_kind     <= TX_REQUEST;
         kernel_start  <= 1'b0;
      end else begin
         kernel_start <= 1'b0;
         case (rx_state)
            RX_IDLE: begin
               if (in_fire) begin
                  if (is_short) begin
                     rx_state <= RX_SHORT_CMD;
                  end else begin
                     rx_state <= RX_SKIP_ADDR;
                     discard  <= ~long_ok;
                  end
               end
            end
            RX_SKIP_ADDR: if (in_fire) rx_state <= RX_PAYLOAD;  // address word unused
            RX_PAYLOAD: begin
               if (in_fire && stream_in.last) begin
                  rx_state <= RX_IDLE;
                  if (!discard) begin
                     bank_full[load_bank] <= 1'b1;
                     matrix_cnt           <= matrix_cnt + 1'b1;
                     pkt_requested        <= 1'b0;
                     kernel_start         <= &full_after;  // both banks loaded
                  end
               end
            end
            RX_SHORT_CMD: begin
               if (in_fire) begin
                  rx_state <= RX_IDLE;
                  if (stream_in.data == CMD_TOGGLE) enabled <= ~enabled;
               end
            end
            default: rx_state <= RX_IDLE;
         endcase

         if (tx_start) last_kind <= tx_kind;
         if (tx_done) begin
            if (last_kind == TX_REQUEST) pkt_requested <= 1'b1;
            if (last_kind == TX_RESULT) res_pending <= 1'b0;
         end

         // kernel consumed both inputs
         if (kernel_done) begin
            bank_full   <= 2'b00;
            res_pending <= 1'b1;
         end
      end
   end

endmodule

/* src/noc_tx_sequencer.sv */
/*
   network transmit sequencer
   sends request, scratchpad notice and result packets one word at a time,
   holding each word until the network takes it
*/
module noc_tx_sequencer import tsqr_pkg::*; (
   input  logic       clk_ctrl,
   input  logic       clk_ctrl_rst_low,
   input  logic       tx_start,
   input  tx_kind_e   tx_kind,
   input  logic       stream_out_ready,
   input  line_t      res_data,
   output stream_s    stream_out,
   output logic       tx_busy,
   output logic       tx_done,
   output line_addr_t res_addr
);

   typedef enum logic [3:0] {
      SQ_IDLE,
      SQ_REQ_HDR,
      SQ_REQ_ARG,
      SQ_SPAD_HDR,
      SQ_SPAD_DST0,
      SQ_SPAD_DST1,
      SQ_SPAD_END,
      SQ_RES_HDR0,
      SQ_RES_HDR1,
      SQ_RES_DATA,
      SQ_RES_GAP0,
      SQ_RES_GAP1
   } sq_state_e;

   sq_state_e    state;
   lane_idx_t    lane_cnt;
   spad_offset_t spad_offset;
   stream_s      out_word;
   logic         last_lane;
   logic         last_line;
   int           lane_shift;

   assign last_lane  = (lane_cnt == lane_idx_t'(LANES - 1));
   assign last_line  = (res_addr == line_addr_t'(LINES - 1));
   assign lane_shift = LANES - 1 - int'(lane_cnt);  // top lane goes first

   ////////////////////////////////////////
   // current word, held while ready is low
   always_comb begin
      out_word = '0;
      case (state)
         SQ_REQ_HDR:   out_word = '{valid: 1'b1, data: REQ_HDR, last: 1'b0};
         SQ_REQ_ARG:   out_word = '{valid: 1'b1, data: REQ_ARG, last: 1'b1};
         SQ_SPAD_HDR:  out_word = '{valid: 1'b1, data: SPAD_HDR, last: 1'b0};
         SQ_SPAD_DST0: begin
            out_word = '{valid: 1'b1, data: SPAD_DST0 | word_t'(spad_offset), last: 1'b0};
         end
         SQ_SPAD_DST1: out_word = '{valid: 1'b1, data: SPAD_DST1, last: 1'b0};
         SQ_SPAD_END:  out_word = '{valid: 1'b1, data: '0, last: 1'b1};
         SQ_RES_HDR0:  out_word = '{valid: 1'b1, data: RES_HDR0, last: 1'b0};
         SQ_RES_HDR1:  out_word = '{valid: 1'b1, data: RES_HDR1, last: 1'b0};
         SQ_RES_DATA: begin
            out_word = '{valid: 1'b1,
                         data:  res_data[lane_shift*WORD_W +: WORD_W],
                         last:  last_lane & last_line};
         end
         default: out_word = '0;  // idle and gap cycles
      endcase
   end

   assign stream_out = out_word;
   assign tx_busy    = (state != SQ_IDLE);
   assign tx_done    = out_word.valid & out_word.last & stream_out_ready;

   ////////////////////////////////////////
   // packet sequencing
   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         state       <= SQ_IDLE;
         lane_cnt    <= '0;
         res_addr    <= '0;
         spad_offset <= '0;
      end else begin
         case (state)
            SQ_IDLE: begin
               if (tx_start) begin
                  lane_cnt <= '0;
                  res_addr <= '0;  // line 0 is ready before the first data word
                  case (tx_kind)
                     TX_REQUEST: state <= SQ_REQ_HDR;
                     TX_SPAD:    state <= SQ_SPAD_HDR;
                     default:    state <= SQ_RES_HDR0;
                  endcase
               end
            end
            SQ_REQ_HDR:   if (stream_out_ready) state <= SQ_REQ_ARG;
            SQ_REQ_ARG:   if (stream_out_ready) state <= SQ_IDLE;
            SQ_SPAD_HDR:  if (stream_out_ready) state <= SQ_SPAD_DST0;
            SQ_SPAD_DST0: if (stream_out_ready) state <= SQ_SPAD_DST1;
            SQ_SPAD_DST1: if (stream_out_ready) state <= SQ_SPAD_END;
            SQ_SPAD_END: begin
               if (stream_out_ready) begin
                  state       <= SQ_IDLE;
                  spad_offset <= spad_offset + spad_offset_t'(SPAD_STEP);
               end
            end
            SQ_RES_HDR0:  if (stream_out_ready) state <= SQ_RES_HDR1;
            SQ_RES_HDR1:  if (stream_out_ready) state <= SQ_RES_DATA;
            SQ_RES_DATA: begin
               if (stream_out_ready) begin
                  if (last_lane) begin
                     lane_cnt <= '0;
                     if (last_line) begin
                        state <= SQ_IDLE;
                     end else begin
                        res_addr <= res_addr + 1'b1;
                        state    <= SQ_RES_GAP0;  // wait out the read latency
                     end
                  end else begin
                     lane_cnt <= lane_cnt + 1'b1;
                  end
               end
            end
            SQ_RES_GAP0: state <= SQ_RES_GAP1;
            SQ_RES_GAP1: state <= SQ_RES_DATA;
            default:     state <= SQ_IDLE;
         endcase
      end
   end

endmodule

/* src/tile_buffer.sv */
/*
   tile buffer
   two lane-writable input banks for the kernel and one result bank
   drained by the transmit sequencer
*/
module tile_buffer import tsqr_pkg::*; (
   input  logic       clk_ctrl,
   input  line_wr_s   line_wr,
   input  kernel_rd_s kernel_rd,
   input  kernel_wr_s kernel_wr,
   input  line_addr_t res_addr,
   output line_t      kernel_rd_data,
   output line_t      res_data
);

   line_t in_mem  [2][LINES];  // indexed by bank_e
   line_t res_mem [LINES];

   ////////////////////////////////////////
   // input banks
   always_ff @(posedge clk_ctrl) begin
      if (line_wr.en) begin
         for (int l = 0; l < LANES; l++) begin
            if (line_wr.lane_mask[l]) begin
               in_mem[line_wr.bank][line_wr.addr][l*WORD_W +: WORD_W] <=
                  line_wr.data[l*WORD_W +: WORD_W];
            end
         end
      end
   end

   // kernel read, data one cycle later
   always_ff @(posedge clk_ctrl) begin
      if (kernel_rd.en) begin
         kernel_rd_data <= in_mem[kernel_rd.bank][kernel_rd.addr];
      end
   end

   ////////////////////////////////////////
   // result bank
   always_ff @(posedge clk_ctrl) begin
      if (kernel_wr.en) begin
         res_mem[kernel_wr.addr] <= kernel_wr.data;  // whole line at once
      end
   end

   always_ff @(posedge clk_ctrl) begin
      res_data <= res_mem[res_addr];  // registered read port
   end

endmodule

/* src/tsqr_pkg.sv */
/*
   tsqr tile controller shared definitions
   sizes, packet words, enums and the bundles passed between the blocks
*/
package tsqr_pkg;

   ////////////////////////////////////////
   // sizes
   localparam int WORD_W       = 32;
   localparam int LANES        = 8;   // words per line, lane 0 in the top bits
   localparam int LINES        = 8;   // lines per bank
   localparam int LANE_W       = $clog2(LANES);
   localparam int LINE_W       = $clog2(LINES);
   localparam int MATRIX_WORDS = 64;  // payload words per matrix
   localparam int WORD_CNT_W   = $clog2(MATRIX_WORDS);
   localparam int MAX_MATRICES = 64;  // request limit for one run
   localparam int SPAD_STEP    = 64;

   typedef logic [WORD_W-1:0]                   word_t;
   typedef logic [LANES*WORD_W-1:0]             line_t;
   typedef logic [LINE_W-1:0]                   line_addr_t;
   typedef logic [LANE_W-1:0]                   lane_idx_t;
   typedef logic [11:0]                         spad_offset_t;
   typedef logic [$clog2(MAX_MATRICES+1)-1:0]   matrix_cnt_t;

   ////////////////////////////////////////
   // packet constants
   // header bits 23:18 of a short packet, bit 28 low
   localparam logic [5:0] SHORT_TYPE_A = 6'd0;
   localparam logic [5:0] SHORT_TYPE_B = 6'd8;

   localparam word_t CMD_TOGGLE = 32'h8000_0000;  // flips the enable
   localparam word_t CMD_SPAD   = 32'd3;          // scratchpad handshake

   localparam word_t REQ_HDR   = 32'b000_0_011_0_010_001_000000_0000_00_001_000;
   localparam word_t REQ_ARG   = 32'h0000_0001;
   localparam word_t RES_HDR0  = 32'b000_1_100_0_010_001_000000_0110_00_001_001;
   localparam word_t RES_HDR1  = 32'b0000_0000_0000_00_001_001_0000_0000_0000;
   localparam word_t SPAD_HDR  = 32'b000_1_101_0_010001_00_0110_0001_00_010000;
   localparam word_t SPAD_DST0 = 32'h0001_0000;   // low 12 bits carry the offset
   localparam word_t SPAD_DST1 = 32'h0001_1000;

   ////////////////////////////////////////
   // enums and bundles
   typedef enum logic {
      BANK_A = 1'b0,
      BANK_B = 1'b1
   } bank_e;

   typedef enum logic [1:0] {
      TX_REQUEST,
      TX_SPAD,
      TX_RESULT
   } tx_kind_e;

   typedef struct packed {
      logic  valid;
      word_t data;
      logic  last;
   } stream_s;

   typedef struct packed {
      logic             en;
      bank_e            bank;
      line_addr_t       addr;
      logic [LANES-1:0] lane_mask;  // bit l enables data[l*WORD_W +: WORD_W]
      line_t            data;
   } line_wr_s;

   typedef struct packed {
      logic       en;
      bank_e      bank;
      line_addr_t addr;
   } kernel_rd_s;

   typedef struct packed {
      logic       en;
      line_addr_t addr;
      line_t      data;
   } kernel_wr_s;

endpackage

/* src/tsqr_tile_ctrl.sv */
/*
   tsqr tile controller
   joins the receive decoder, matrix loader, tile buffer and transmit sequencer
*/
module tsqr_tile_ctrl import tsqr_pkg::*; (
   input  logic       clk_ctrl,
   input  logic       clk_ctrl_rst_low,
   input  stream_s    stream_in,
   output logic       stream_in_ready,
   output stream_s    stream_out,
   input  logic       stream_out_ready,
   output logic       kernel_start,
   input  logic       kernel_done,
   input  kernel_rd_s kernel_rd,
   output line_t      kernel_rd_data,
   input  kernel_wr_s kernel_wr
);

   stream_s    load_word;
   bank_e      load_bank;
   line_wr_s   line_wr;
   logic       tx_start;
   tx_kind_e   tx_kind;
   logic       tx_busy;
   logic       tx_done;
   line_addr_t res_addr;
   line_t      res_data;

   noc_rx_decoder u_rx_decoder (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .stream_in        (stream_in),
      .tx_busy          (tx_busy),
      .tx_done          (tx_done),
      .kernel_done      (kernel_done),
      .stream_in_ready  (stream_in_ready),
      .load_word        (load_word),
      .load_bank        (load_bank),
      .tx_start         (tx_start),
      .tx_kind          (tx_kind),
      .kernel_start     (kernel_start)
   );

   matrix_loader u_loader (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .load_word        (load_word),
      .load_bank        (load_bank),
      .line_wr          (line_wr)
   );

   tile_buffer u_buffer (
      .clk_ctrl         (clk_ctrl),
      .line_wr          (line_wr),
      .kernel_rd        (kernel_rd),
      .kernel_wr        (kernel_wr),
      .res_addr         (res_addr),
      .kernel_rd_data   (kernel_rd_data),
      .res_data         (res_data)
   );

   noc_tx_sequencer u_tx_sequencer (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .tx_start         (tx_start),
      .tx_kind          (tx_kind),
      .stream_out_ready (stream_out_ready),
      .res_data         (res_data),
      .stream_out       (stream_out),
      .tx_busy          (tx_busy),
      .tx_done          (tx_done),
      .res_addr         (res_addr)
   );

endmodule

/* verification/tsqr_tile_tb.sv */
/*
   tsqr tile controller testbench
   directed tests with a network model on both streams and a small kernel model
*/
module tsqr_tile_tb import tsqr_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT = 4000;  // cycles per wait loop
   localparam word_t LONG_HDR = 32'h1000_0000;  // bit 28 set

   logic       clk_ctrl;
   logic       clk_ctrl_rst_low;
   stream_s    stream_in;
   logic       stream_in_ready;
   stream_s    stream_out;
   logic       stream_out_ready;
   logic       kernel_start;
   logic       kernel_done;
   kernel_rd_s kernel_rd;
   line_t      kernel_rd_data;
   kernel_wr_s kernel_wr;

   word_t   words [3][MATRIX_WORDS];  // bank A matrix, bank B matrix, result
   stream_s out_q [$];                // words taken by the network
   word_t   data_seed  = 32'd43;
   word_t   ready_seed = 32'd43;
   logic    drop_ready = 1'b0;
   int      start_count = 0;
   int      word_errs = 0;
   int      line_errs = 0;
   int      flag_errs = 0;
   int      timeouts = 0;

   tsqr_tile_ctrl dut (.*);

   initial begin
      clk_ctrl = 1'b0;
      forever #20 clk_ctrl = ~clk_ctrl;
   end

   ////////////////////////////////////////
   // helpers

   function automatic word_t lcg_next(inout word_t state);
      state = state * 32'd1664525 + 32'd1013904223;
      return state;
   endfunction

   // lane 0 ends up in the top word
   function automatic line_t pack_line(int m, int ln);
      line_t l;
      l = '0;
      for (int lane = 0; lane < LANES; lane++) begin
         l = (l << WORD_W) | line_t'(words[m][ln*LANES + lane]);
      end
      return l;
   endfunction

   task automatic print_counts();
      $display("errors: %0d word, %0d line, %0d flag, %0d timeout",
               word_errs, line_errs, flag_errs, timeouts);
   endtask

   task automatic abort_on_timeout(string what);
      $display("timeout at %0d ns while waiting for %s", $time, what);
      timeouts++;
      print_counts();
      $display("TEST FAILED");
      $finish;
   endtask

   task automatic check_word(word_t got, word_t exp, string what);
      if (got !== exp) begin
         $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
         word_errs++;
      end
   endtask

   task automatic check_line(line_t got, line_t exp, string what);
      if (got !== exp) begin
         $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
         line_errs++;
      end
   endtask

   task automatic check_flag(logic got, logic exp, string what);
      if (got !== exp) begin
         $display("FAILED at %0d ns: %s, got %b, expected %b", $time, what, got, exp);
         flag_errs++;
      end
   endtask

   ////////////////////////////////////////
   // network and kernel models

   // output side takes words and may drop ready
   initial begin
      word_t rnd;
      forever begin
         @(negedge clk_ctrl);
         rnd = lcg_next(ready_seed);
         stream_out_ready = drop_ready ? (rnd[20] | rnd[27]) : 1'b1;
         if (stream_out.valid && stream_out_ready) out_q.push_back(stream_out);
         // input stalls while a packet goes out
         if (stream_out.valid) begin
            check_flag(stream_in_ready, 1'b0, "stream_in_ready during output");
         end
         if (kernel_start) start_count++;
      end
   end

   task automatic send_word(word_t data, logic last);
      int cycles = 0;
      @(negedge clk_ctrl);
      stream_in = '{valid: 1'b1, data: data, last: last};
      while (!stream_in_ready) begin  // word moves at the next rising edge
         if (cycles >= WAIT_LIMIT) abort_on_timeout("stream_in_ready");
         @(negedge clk_ctrl);
         cycles++;
      end
   endtask

   task automatic end_packet();
      @(negedge clk_ctrl);
      stream_in = '0;
   endtask

   task automatic send_short(word_t cmd);
      send_word(word_t'(SHORT_TYPE_B) << 18, 1'b0);
      send_word(cmd, 1'b1);
      end_packet();
   endtask

   task automatic send_matrix(int m);
      send_word(LONG_HDR, 1'b0);
      send_word(32'h0000_1234, 1'b0);  // address word, dropped by the DUT
      for (int i = 0; i < MATRIX_WORDS; i++) send_word(words[m][i], i == MATRIX_WORDS - 1);
      end_packet();
   endtask

   task automatic fill_words(int m);
      for (int i = 0; i < MATRIX_WORDS; i++) words[m][i] = lcg_next(data_seed);
   endtask

   // pops the next outgoing word and checks it
   task automatic expect_out(word_t data, logic last, string what);
      stream_s w;
      int cycles = 0;
      while (out_q.size() == 0) begin
         if (cycles >= WAIT_LIMIT) abort_on_timeout(what);
         @(negedge clk_ctrl);
         cycles++;
      end
      w = out_q.pop_front();
      check_word(w.data, data, what);
      check_flag(w.last, last, {what, " last"});
   endtask

   task automatic check_bank_line(bank_e bank, int m, int ln);
      @(negedge clk_ctrl);
      kernel_rd = '{en: 1'b1, bank: bank, addr: line_addr_t'(ln)};
      @(negedge clk_ctrl);
      kernel_rd = '0;
      check_line(kernel_rd_data, pack_line(m, ln), $sformatf("bank %0d line %0d", bank, ln));
   endtask

   ////////////////////////////////////////
   // tests

   task automatic test_enable_request();
      repeat (50) @(negedge clk_ctrl);
      check_flag(out_q.size() == 0, 1'b1, "no output while disabled");
      send_short(CMD_TOGGLE);
      expect_out(REQ_HDR, 1'b0, "first request header");
      expect_out(REQ_ARG, 1'b1, "first request argument");
   endtask

   task automatic test_first_matrix();
      fill_words(0);
      send_matrix(0);
      expect_out(REQ_HDR, 1'b0, "second request header");
      expect_out(REQ_ARG, 1'b1, "second request argument");
      for (int ln = 0; ln < LINES; ln++) check_bank_line(BANK_A, 0, ln);
   endtask

   task automatic test_second_matrix();
      int cycles = 0;
      fill_words(1);
      send_matrix(1);
      while (start_count == 0) begin
         if (cycles >= WAIT_LIMIT) abort_on_timeout("kernel_start");
         @(negedge clk_ctrl);
         cycles++;
      end
      repeat (40) @(negedge clk_ctrl);
      check_flag(start_count == 1, 1'b1, "single kernel_start pulse");
      check_flag(out_q.size() == 0, 1'b1, "no request with both banks full");
      check_bank_line(BANK_B, 1, 0);
   endtask

   task automatic test_result_packet();
      fill_words(2);
      for (int ln = 0; ln < LINES; ln++) begin
         @(negedge clk_ctrl);
         kernel_wr = '{en: 1'b1, addr: line_addr_t'(ln), data: pack_line(2, ln)};
      end
      @(negedge clk_ctrl);
      kernel_wr   = '0;
      kernel_done = 1'b1;
      drop_ready  = 1'b1;  // back-pressure from here on
      @(negedge clk_ctrl);
      kernel_done = 1'b0;
      expect_out(RES_HDR0, 1'b0, "result header 0");
      expect_out(RES_HDR1, 1'b0, "result header 1");
      for (int i = 0; i < MATRIX_WORDS; i++) begin
         expect_out(words[2][i], i == MATRIX_WORDS - 1, $sformatf("result word %0d", i));
      end
      // banks are free again, so the next matrix is requested
      expect_out(REQ_HDR, 1'b0, "third request header");
      expect_out(REQ_ARG, 1'b1, "third request argument");
      drop_ready = 1'b0;
   endtask

   task automatic test_spad_notices();
      for (int n = 0; n < 2; n++) begin
         send_short(CMD_SPAD);
         expect_out(SPAD_HDR, 1'b0, "notice header");
         expect_out(SPAD_DST0 | word_t'(n * SPAD_STEP), 1'b0, "notice offset");
         expect_out(SPAD_DST1, 1'b0, "notice destination");
         expect_out(32'd0, 1'b1, "notice end");
      end
   endtask

   task automatic test_disable();
      send_short(CMD_TOGGLE);
      fill_words(1);
      send_matrix(1);
      repeat (50) @(negedge clk_ctrl);
      check_flag(out_q.size() == 0, 1'b1, "no output after disable");
      check_bank_line(BANK_A, 0, 0);  // long packet was not loaded
   endtask

   ////////////////////////////////////////
   // main sequence
   initial begin
      clk_ctrl_rst_low = 1'b0;
      stream_in        = '0;
      stream_out_ready = 1'b1;
      kernel_done      = 1'b0;
      kernel_rd        = '0;
      kernel_wr        = '0;
      repeat (2) @(posedge clk_ctrl);
      @(negedge clk_ctrl);
      clk_ctrl_rst_low = 1'b1;

      test_enable_request();
      test_first_matrix();
      test_second_matrix();
      test_result_packet();
      test_spad_notices();
      test_disable();

      print_counts();
      if (word_errs + line_errs + flag_errs == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
